/* hdl/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

	typedef logic [7:0] lcd_byte_t;		// one panel bus byte
	typedef logic [6:0] lcd_cfg_t;		// static init configuration
	typedef logic [16:0] cycle_cnt_t;	// long wait at 50 MHz fits

	// panel timing in microseconds
	localparam int POWERUP_US = 500;
	localparam int SETUP_US = 1;		// rs, rw, data before e rises
	localparam int PULSE_US = 13;		// e high
	localparam int HOLD_US = 13;		// e low after the pulse
	localparam int SHORT_WAIT_US = 50;	// whole command, ordinary
	localparam int LONG_WAIT_US = 2000;	// whole command, clear and home

	// fixed command bytes
	localparam lcd_byte_t CMD_PRESET = 8'h30;
	localparam lcd_byte_t CMD_CLEAR = 8'h01;
	localparam lcd_byte_t CMD_HOME = 8'h02;	// bit 0 is don't care

	typedef enum logic [2:0] {
		DEC_POWERUP,
		DEC_INIT_ISSUE,
		DEC_INIT_WAIT,
		DEC_IDLE,
		DEC_USER_WAIT
	} decode_state_t;

	typedef enum logic [2:0] {
		EXE_IDLE,
		EXE_SETUP,
		EXE_PULSE,
		EXE_HOLD,
		EXE_SETTLE
	} exec_state_t;

endpackage

`default_nettype wire

/* hdl/lcd_cmd_if.sv */
`default_nettype none

interface lcd_cmd_if;

	logic start;			// one-cycle strobe
	logic rs;
	logic rw;
	lcd_pkg::lcd_byte_t data;
	logic long_wait;		// clear or home
	logic busy;			// execute active

	modport dec (
		output start, rs, rw, data, long_wait,
		input busy
	);

	modport exe (
		input start, rs, rw, data, long_wait,
		output busy
	);

endinterface

`default_nettype wire

/* hdl/lcd_cmd_decode.sv */
`default_nettype none

module lcd_cmd_decode #(
	parameter int clk_mhz = 50
) (
	input logic clk,
	input logic rst_n,
	input lcd_pkg::lcd_cfg_t init_cfg,
	input logic lcd_enable,
	input logic [9:0] lcd_bus,
	output logic busy,
	lcd_cmd_if.dec cmd
);

	localparam lcd_pkg::cycle_cnt_t powerup_end =
		lcd_pkg::cycle_cnt_t'(lcd_pkg::POWERUP_US * clk_mhz - 1);
	localparam logic [2:0] init_last = 3'd4;	// five init commands

	lcd_pkg::decode_state_t state;
	lcd_pkg::cycle_cnt_t cnt;
	logic [2:0] init_idx;
	logic load_init;
	logic load_host;
	lcd_pkg::lcd_byte_t init_next;
	logic rs_q;
	logic rw_q;
	lcd_pkg::lcd_byte_t data_q;
	logic long_q;

	function automatic lcd_pkg::lcd_byte_t init_byte(input logic [2:0] idx,
			input lcd_pkg::lcd_cfg_t cfg);
		case (idx)
			3'd0: init_byte = lcd_pkg::CMD_PRESET;
			3'd1: init_byte = {4'b0011, cfg[6], cfg[5], 2'b00};	// function set
			3'd2: init_byte = {5'b00001, cfg[4:2]};		// display on/off
			3'd3: init_byte = lcd_pkg::CMD_CLEAR;
			default: init_byte = {6'b000001, cfg[1:0]};	// entry mode
		endcase
	endfunction

	// clear and return home need the long settle
	function automatic logic is_long(input logic rs, input logic rw,
			input lcd_pkg::lcd_byte_t b);
		is_long = !rs && !rw &&
			(b == lcd_pkg::CMD_CLEAR || (b & 8'hfe) == lcd_pkg::CMD_HOME);
	endfunction

	assign load_host = (state == lcd_pkg::DEC_IDLE) && lcd_enable && !cmd.busy;
	assign load_init = (state == lcd_pkg::DEC_POWERUP && cnt == powerup_end) ||
		(state == lcd_pkg::DEC_INIT_WAIT && !cmd.busy && init_idx != init_last);
	assign init_next = init_byte((state == lcd_pkg::DEC_POWERUP) ? 3'd0 : init_idx + 3'd1,
		init_cfg);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= lcd_pkg::DEC_POWERUP;
			cnt <= '0;
			init_idx <= '0;
		end else begin
			case (state)
				lcd_pkg::DEC_POWERUP: begin
					if (cnt == powerup_end)
						state <= lcd_pkg::DEC_INIT_ISSUE;
					else
						cnt <= cnt + 1'b1;
				end
				lcd_pkg::DEC_INIT_ISSUE: state <= lcd_pkg::DEC_INIT_WAIT;
				lcd_pkg::DEC_INIT_WAIT: begin
					if (!cmd.busy) begin		// previous init command done
						if (init_idx == init_last) begin
							state <= lcd_pkg::DEC_IDLE;
						end else begin
							init_idx <= init_idx + 3'd1;
							state <= lcd_pkg::DEC_INIT_ISSUE;
						end
					end
				end
				lcd_pkg::DEC_IDLE: begin
					if (load_host)
						state <= lcd_pkg::DEC_USER_WAIT;
				end
				default: state <= lcd_pkg::DEC_IDLE;	// start issued, back to idle
			endcase
		end
	end

	// command latch, held until the next load
	always_ff @(posedge clk) begin
		if (load_init) begin
			rs_q <= 1'b0;
			rw_q <= 1'b0;
			data_q <= init_next;
			long_q <= is_long(1'b0, 1'b0, init_next);
		end else if (load_host) begin
			rs_q <= lcd_bus[9];
			rw_q <= lcd_bus[8];
			data_q <= lcd_bus[7:0];
			long_q <= is_long(lcd_bus[9], lcd_bus[8], lcd_bus[7:0]);
		end
	end

	assign cmd.start = (state == lcd_pkg::DEC_INIT_ISSUE) ||
		(state == lcd_pkg::DEC_USER_WAIT);
	assign cmd.rs = rs_q;
	assign cmd.rw = rw_q;
	assign cmd.data = data_q;
	assign cmd.long_wait = long_q;
	assign busy = (state != lcd_pkg::DEC_IDLE);

endmodule

`default_nettype wire

/* hdl/lcd_bus_timer.sv */
`default_nettype none

module lcd_bus_timer #(
	parameter int clk_mhz = 50
) (
	input logic clk,
	input logic rst_n,
	lcd_cmd_if.exe cmd,
	output logic e,
	output logic rs,
	output logic rw,
	output lcd_pkg::lcd_byte_t data_out,
	output logic data_oe,
	output logic rd_sample
);

	// last count of each phase, counted from the first setup cycle
	localparam lcd_pkg::cycle_cnt_t setup_end =
		lcd_pkg::cycle_cnt_t'(lcd_pkg::SETUP_US * clk_mhz - 1);
	localparam lcd_pkg::cycle_cnt_t pulse_end =
		lcd_pkg::cycle_cnt_t'((lcd_pkg::SETUP_US + lcd_pkg::PULSE_US) * clk_mhz - 1);
	localparam lcd_pkg::cycle_cnt_t hold_end =
		lcd_pkg::cycle_cnt_t'((lcd_pkg::SETUP_US + lcd_pkg::PULSE_US +
		lcd_pkg::HOLD_US) * clk_mhz - 1);
	localparam lcd_pkg::cycle_cnt_t short_end =
		lcd_pkg::cycle_cnt_t'(lcd_pkg::SHORT_WAIT_US * clk_mhz - 1);
	localparam lcd_pkg::cycle_cnt_t long_end =
		lcd_pkg::cycle_cnt_t'(lcd_pkg::LONG_WAIT_US * clk_mhz - 1);

	lcd_pkg::exec_state_t state;
	lcd_pkg::cycle_cnt_t cnt;
	lcd_pkg::cycle_cnt_t settle_end;

	assign settle_end = cmd.long_wait ? long_end : short_end;	// held stable by decode

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= lcd_pkg::EXE_IDLE;
			cnt <= '0;
			e <= 1'b0;
			rs <= 1'b0;
			rw <= 1'b0;
			data_out <= '0;
			data_oe <= 1'b0;
			rd_sample <= 1'b0;
		end else begin
			rd_sample <= 1'b0;
			if (state != lcd_pkg::EXE_IDLE)
				cnt <= cnt + 1'b1;
			case (state)
				lcd_pkg::EXE_IDLE: begin
					if (cmd.start) begin
						state <= lcd_pkg::EXE_SETUP;
						cnt <= '0;
						rs <= cmd.rs;
						rw <= cmd.rw;
						data_out <= cmd.data;
						data_oe <= !cmd.rw;		// drive bus on writes only
					end
				end
				lcd_pkg::EXE_SETUP: begin
					if (cnt == setup_end) begin
						state <= lcd_pkg::EXE_PULSE;
						e <= 1'b1;
					end
				end
				lcd_pkg::EXE_PULSE: begin
					if (cnt == pulse_end) begin
						state <= lcd_pkg::EXE_HOLD;
						e <= 1'b0;
						rd_sample <= rw;		// panel byte valid at e fall
					end
				end
				lcd_pkg::EXE_HOLD: begin
					if (cnt == hold_end)
						state <= lcd_pkg::EXE_SETTLE;
				end
				lcd_pkg::EXE_SETTLE: begin
					if (cnt == settle_end) begin
						state <= lcd_pkg::EXE_IDLE;
						rs <= 1'b0;
						rw <= 1'b0;
						data_out <= '0;
						data_oe <= 1'b0;
					end
				end
				default: state <= lcd_pkg::EXE_IDLE;
			endcase
		end
	end

	assign cmd.busy = (state != lcd_pkg::EXE_IDLE);

endmodule

`default_nettype wire

/* hdl/lcd_read_capture.sv */
`default_nettype none

module lcd_read_capture (
	input logic clk,
	input logic rst_n,
	input logic rd_sample,
	input lcd_pkg::lcd_byte_t data_in,
	output lcd_pkg::lcd_byte_t read_data,
	output logic read_valid
);

	// valid strobe follows the sample strobe by one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			read_valid <= 1'b0;
		else
			read_valid <= rd_sample;
	end

	always_ff @(posedge clk) begin
		if (rd_sample)
			read_data <= data_in;	// held until the next read
	end

endmodule

`default_nettype wire

/* hdl/lcd_ctrl_top.sv */
`default_nettype none

module lcd_ctrl_top #(
	parameter int clk_mhz = 50
) (
	input logic clk,
	input logic rst_n,
	input lcd_pkg::lcd_cfg_t init_cfg,
	input logic lcd_enable,
	input logic [9:0] lcd_bus,		// rs, rw, data
	input lcd_pkg::lcd_byte_t data_in,
	output logic e,
	output logic rs,
	output logic rw,
	output lcd_pkg::lcd_byte_t data_out,
	output logic data_oe,
	output logic busy,
	output lcd_pkg::lcd_byte_t read_data,
	output logic read_valid
);

	logic dec_busy;
	logic rd_sample;

	lcd_cmd_if cmd_bus ();

	lcd_cmd_decode #(.clk_mhz(clk_mhz)) u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.init_cfg(init_cfg),
		.lcd_enable(lcd_enable),
		.lcd_bus(lcd_bus),
		.busy(dec_busy),
		.cmd(cmd_bus)
	);

	lcd_bus_timer #(.clk_mhz(clk_mhz)) u_exec (
		.clk(clk),
		.rst_n(rst_n),
		.cmd(cmd_bus),
		.e(e),
		.rs(rs),
		.rw(rw),
		.data_out(data_out),
		.data_oe(data_oe),
		.rd_sample(rd_sample)
	);

	lcd_read_capture u_capture (
		.clk(clk),
		.rst_n(rst_n),
		.rd_sample(rd_sample),
		.data_in(data_in),
		.read_data(read_data),
		.read_valid(read_valid)
	);

	assign busy = dec_busy | cmd_bus.busy;	// covers init and the issue cycle

endmodule

`default_nettype wire

/* verification/lcd_panel_model.sv */
`default_nettype none

module lcd_panel_model (
	input logic e,
	input logic rs,
	input logic rw,
	input lcd_pkg::lcd_byte_t data_out,
	output lcd_pkg::lcd_byte_t data_in
);

	timeunit 1ns;
	timeprecision 100ps;

	logic [9:0] log_q[$];			// {rs, rw, data} per command
	lcd_pkg::lcd_byte_t last_wr = '0;	// last data byte written with rs high

	// the panel latches on the falling enable edge of a real pulse
	always begin
		@(posedge e);
		@(negedge e);
		log_q.push_back({rs, rw, data_out});
		if (rs && !rw)
			last_wr <= data_out;
	end

	// read answer only while the controller has turned the bus around
	assign data_in = rw ? last_wr : 8'h00;

endmodule

`default_nettype wire

/* verification/lcd_ctrl_tb.sv */
`default_nettype none

module lcd_ctrl_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// init is about 2700 cycles, each later command at most 2001
	localparam int timeout_cycles = 20000;
	localparam int short_busy = 51;
	localparam int long_busy = 2001;

	logic clk;
	logic rst_n;
	lcd_pkg::lcd_cfg_t init_cfg;
	logic lcd_enable;
	logic [9:0] lcd_bus;
	lcd_pkg::lcd_byte_t data_in;
	logic e;
	logic rs;
	logic rw;
	lcd_pkg::lcd_byte_t data_out;
	logic data_oe;
	logic busy;
	lcd_pkg::lcd_byte_t read_data;
	logic read_valid;

	logic [31:0] lfsr = 32'hdaa73345;
	logic [9:0] expect_q[$];	// commands the panel should have seen
	int checked = 0;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	lcd_ctrl_top #(.clk_mhz(1)) dut0 (
		.clk(clk), .rst_n(rst_n), .init_cfg(init_cfg), .lcd_enable(lcd_enable),
		.lcd_bus(lcd_bus), .data_in(data_in), .e(e), .rs(rs), .rw(rw),
		.data_out(data_out), .data_oe(data_oe), .busy(busy),
		.read_data(read_data), .read_valid(read_valid)
	);

	lcd_panel_model panel0 (
		.e(e), .rs(rs), .rw(rw), .data_out(data_out), .data_in(data_in)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// x^32 + x^22 + x^2 + x + 1, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic compare_byte(input lcd_pkg::lcd_byte_t got, input lcd_pkg::lcd_byte_t exp,
			input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s is %02h, expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic compare_bit(input logic got, input logic exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("ERROR at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compare_int(input int got, input int exp, input string what);
		checks++;
		if (got != exp) begin
			errors++;
			$display("ERROR at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	// init bytes as the panel datasheet orders them
	function automatic lcd_pkg::lcd_byte_t init_expect(input int idx, input lcd_pkg::lcd_cfg_t c);
		lcd_pkg::lcd_byte_t b;
		case (idx)
			0: b = 8'h30;
			1: b = 8'h30 | (8'(c[6]) << 3) | (8'(c[5]) << 2);
			2: b = 8'h08 | 8'(c[4:2]);
			3: b = 8'h01;
			default: b = 8'h04 | 8'(c[1:0]);
		endcase
		return b;
	endfunction

	task automatic check_log();
		if (panel0.log_q.size() != expect_q.size()) begin
			errors++;
			$display("panel logged %0d commands but %0d were expected",
				panel0.log_q.size(), expect_q.size());
		end
		for (int i = checked; i < expect_q.size() && i < panel0.log_q.size(); i++) begin
			compare_bit(panel0.log_q[i][9], expect_q[i][9], "logged rs");
			compare_bit(panel0.log_q[i][8], expect_q[i][8], "logged rw");
			compare_byte(panel0.log_q[i][7:0], expect_q[i][7:0], "logged data");
		end
		checked = expect_q.size();
	endtask

	// called and returns 5 ns after a rising edge
	task automatic issue_cmd(input logic c_rs, input logic c_rw, input lcd_pkg::lcd_byte_t c_data);
		int guard;
		guard = 0;
		while (busy && guard < 5000) begin
			@(posedge clk);
			#5;
			guard++;
		end
		if (busy) begin
			errors++;
			$display("controller stayed busy before a host command");
		end
		lcd_enable = 1'b1;
		lcd_bus = {c_rs, c_rw, c_data};
		expect_q.push_back({c_rs, c_rw, c_data});
		@(posedge clk);
		#5;
		lcd_enable = 1'b0;
	endtask

	task automatic count_busy(output int n);
		n = 0;
		while (busy && n < 3000) begin
			n++;
			@(posedge clk);
			#5;
		end
	endtask

	task automatic test_init();
		int n;
		compare_bit(busy, 1'b1, "busy in reset");
		compare_bit(e, 1'b0, "e in reset");
		compare_bit(rs, 1'b0, "rs in reset");
		compare_bit(rw, 1'b0, "rw in reset");
		compare_byte(data_out, 8'h00, "data_out in reset");
		compare_bit(data_oe, 1'b0, "data_oe in reset");
		compare_bit(read_valid, 1'b0, "read_valid in reset");
		rst_n = 1'b1;
		for (int i = 0; i < 5; i++)
			expect_q.push_back({2'b00, init_expect(i, init_cfg)});
		n = 0;
		while (busy && n < 4000) begin
			n++;
			@(posedge clk);
			#5;
		end
		compare_bit(busy, 1'b0, "busy after init");
		check_log();
	endtask

	task automatic test_pulse_shape();
		logic [31:0] r;
		logic [9:0] pins;
		logic [9:0] prev;
		int e_cycles;
		int guard;
		logic rose;
		logic fell;
		e_cycles = 0;
		guard = 0;
		rose = 1'b0;
		fell = 1'b0;
		r = rand_bits(8);
		issue_cmd(1'b1, 1'b0, r[7:0]);
		prev = {rs, rw, data_out};
		while (busy && guard < 100) begin
			pins = {rs, rw, data_out};
			if (e) begin
				if (!rose) begin
					compare_byte(prev[7:0], r[7:0], "data_out before e rises");
					compare_bit(prev[9], 1'b1, "rs before e rises");
					compare_bit(prev[8], 1'b0, "rw before e rises");
				end
				rose = 1'b1;
				e_cycles++;
				compare_bit(pins[9], 1'b1, "rs while e high");
				compare_bit(pins[8], 1'b0, "rw while e high");
				compare_byte(pins[7:0], r[7:0], "data_out while e high");
				compare_bit(data_oe, 1'b1, "data_oe on a write");
			end else if (rose && !fell) begin
				fell = 1'b1;
				compare_bit(pins[9], 1'b1, "rs as e falls");
				compare_bit(pins[8], 1'b0, "rw as e falls");
				compare_byte(pins[7:0], r[7:0], "data_out as e falls");
			end
			prev = pins;
			guard++;
			@(posedge clk);
			#5;
		end
		if (!rose) begin
			errors++;
			$display("e never went high during a host write");
		end
		compare_int(e_cycles, 13, "e high cycles");
		check_log();
	endtask

	task automatic test_write();
		logic [31:0] r;
		lcd_pkg::lcd_byte_t ord[3];
		int n;
		ord = '{8'h0e, 8'h18, 8'hc5};
		for (int i = 0; i < 6; i++) begin
			r = rand_bits(8);
			if (i % 2 == 0)
				issue_cmd(1'b1, 1'b0, r[7:0]);
			else
				issue_cmd(1'b0, 1'b0, ord[i / 2]);
			count_busy(n);
			compare_int(n, short_busy, "busy cycles for a short command");
		end
		check_log();
	endtask

	task automatic test_long_wait();
		lcd_pkg::lcd_byte_t cmds[3];
		int n;
		cmds = '{8'h01, 8'h02, 8'h03};
		foreach (cmds[i]) begin
			issue_cmd(1'b0, 1'b0, cmds[i]);
			count_busy(n);
			compare_int(n, long_busy, "busy cycles for clear or home");
		end
		check_log();
	endtask

	task automatic test_read();
		logic [31:0] r;
		int n;
		int valid_n;
		logic oe_seen;
		valid_n = 0;
		oe_seen = 1'b0;
		r = rand_bits(8);
		issue_cmd(1'b1, 1'b0, r[7:0]);
		count_busy(n);
		issue_cmd(1'b1, 1'b1, 8'h00);
		n = 0;
		while (busy && n < 3000) begin
			oe_seen = oe_seen | data_oe;
			if (read_valid) begin
				valid_n++;
				compare_byte(read_data, r[7:0], "read data");
			end
			n++;
			@(posedge clk);
			#5;
		end
		compare_bit(oe_seen, 1'b0, "data_oe during a read");
		compare_int(valid_n, 1, "read_valid pulses");
		compare_int(n, short_busy, "busy cycles for a read");
		check_log();
	endtask

	task automatic test_busy_ignore();
		logic [31:0] r;
		int n;
		r = rand_bits(8);
		issue_cmd(1'b1, 1'b0, r[7:0]);
		lcd_enable = 1'b1;		// right after acceptance
		lcd_bus = {2'b10, ~r[7:0]};
		@(posedge clk);
		#5;
		lcd_enable = 1'b0;
		repeat (20) @(posedge clk);
		#5;
		lcd_enable = 1'b1;		// mid command
		lcd_bus = 10'h001;
		@(posedge clk);
		#5;
		lcd_enable = 1'b0;
		count_busy(n);
		compare_int(n, short_busy - 22, "busy cycles left after ignored enables");
		for (int i = 0; i < 5; i++) begin
			compare_bit(busy, 1'b0, "busy after an ignored enable");
			@(posedge clk);
			#5;
		end
		check_log();
	endtask

	initial begin
		while (cycles < timeout_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("run timed out after %0d cycles", cycles);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin
		logic [31:0] r;
		rst_n = 1'b0;
		lcd_enable = 1'b0;
		lcd_bus = '0;
		r = rand_bits(7);
		init_cfg = r[6:0];
		repeat (16) @(posedge clk);
		#5;
		test_init();
		test_pulse_shape();
		test_write();
		test_long_wait();
		test_read();
		test_busy_ignore();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
hdl/lcd_pkg.sv
hdl/lcd_cmd_if.sv
hdl/lcd_cmd_decode.sv
hdl/lcd_bus_timer.sv
hdl/lcd_read_capture.sv
hdl/lcd_ctrl_top.sv
verification/lcd_panel_model.sv
verification/lcd_ctrl_tb.sv
